// ==== hdl/rvfi_params.svh ====
/*
 * Retirement trace unit parameters
 * Widths, pipeline depth, debug cause codes and checker rule indices
 */
`ifndef RVFI_PARAMS_SVH
`define RVFI_PARAMS_SVH

// Register and cause widths
`define RVFI_XLEN 32
`define RVFI_NSTAGES 4
`define RVFI_ECAUSE_W 6
`define RVFI_DCAUSE_W 3
`define RVFI_TRAP_W 12

// Debug cause code reported for single step entry
`define DBG_CAUSE_STEP 3'h4

// Bit positions in the checker error vector
`define CHK_NUM_RULES 5
`define CHK_TRAP_NO_INTR 0
`define CHK_TRAP_NO_DBG 1
`define CHK_DBG_CAUSE 2
`define CHK_STEP_CAUSE 3
`define CHK_STEP_NO_TRAP 4
`endif

// ==== hdl/rvfi_pkg.sv ====
/*
 * Retirement trace types
 * Holds the trap word shared by retirement, checker and top level
 */
`include "rvfi_params.svh"

package rvfi_pkg;

  //////////////////////////////////////////////////////////////////////
  // Trap word
  //////////////////////////////////////////////////////////////////////

  // The raw view serves the any-trap test and storage
  // Field layout from LSB: trap, exception, debug, exception cause, debug cause
  typedef union packed {
    logic [`RVFI_TRAP_W-1:0] raw;
    struct packed {
      logic [`RVFI_DCAUSE_W-1:0] debug_cause;
      logic [`RVFI_ECAUSE_W-1:0] exception_cause;
      logic                      debug;
      logic                      exception;
      logic                      trap;
    } f;
  } rvfi_trap_u;

endpackage

// ==== hdl/trap_capture.sv ====
/*
 * Trap capture slots
 * Records trap-entry and debug-entry acknowledges against the IF instruction
 * and shifts one slot per stage down to WB on every pipeline step
 */
`timescale 1ns/1ps
`include "rvfi_params.svh"

module trap_capture (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      step_i,
  input  logic                      fetch_valid_i,
  input  logic                      irq_ack_i,
  input  logic                      dbg_ack_i,
  input  logic [`RVFI_DCAUSE_W-1:0] dbg_cause_i,
  output logic                      wb_valid_o,
  output logic                      wb_intr_o,
  output logic [`RVFI_DCAUSE_W-1:0] wb_dbg_o
);

  // Slot 0 is IF, slot RVFI_NSTAGES-1 is WB
  logic [`RVFI_NSTAGES-1:0]                     valid_q, valid_d;
  logic [`RVFI_NSTAGES-1:0]                     intr_q, intr_d;
  logic [`RVFI_NSTAGES-1:0][`RVFI_DCAUSE_W-1:0] dbg_q, dbg_d;

  //////////////////////////////////////////////////////////////////////
  // Next slot contents
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    valid_d = valid_q;
    intr_d  = intr_q;
    dbg_d   = dbg_q;

    // On a step every record moves one stage toward WB
    // The old WB record has retired and is overwritten here
    if (step_i) begin
      for (int s = `RVFI_NSTAGES - 1; s > 0; s--) begin
        valid_d[s] = valid_q[s-1];
        intr_d[s]  = intr_q[s-1];
        dbg_d[s]   = dbg_q[s-1];
      end
      // A new fetch enters IF with no events yet
      valid_d[0] = fetch_valid_i;
      intr_d[0]  = 1'b0;
      dbg_d[0]   = '0;
    end

    // Acknowledges land in IF after the shift, so with a step in the
    // same cycle they belong to the instruction that just entered IF
    if (irq_ack_i) begin
      intr_d[0] = 1'b1;
    end
    if (dbg_ack_i) begin
      dbg_d[0] = dbg_cause_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      intr_q  <= '0;
      dbg_q   <= '0;
    end else begin
      valid_q <= valid_d;
      intr_q  <= intr_d;
      dbg_q   <= dbg_d;
    end
  end

  // The WB slot feeds retirement
  assign wb_valid_o = valid_q[`RVFI_NSTAGES-1];
  assign wb_intr_o  = intr_q[`RVFI_NSTAGES-1];
  assign wb_dbg_o   = dbg_q[`RVFI_NSTAGES-1];

endmodule

// ==== hdl/rvfi_retire.sv ====
/*
 * Retirement record
 * Builds the trap word from WB events and registers the trace record
 * on each retiring step, alongside the mcause shadow
 */
`timescale 1ns/1ps
`include "rvfi_params.svh"

module rvfi_retire import rvfi_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      step_i,
  input  logic                      wb_valid_i,
  input  logic                      wb_intr_i,
  input  logic [`RVFI_DCAUSE_W-1:0] wb_dbg_i,
  input  logic                      wb_exc_i,
  input  logic [`RVFI_ECAUSE_W-1:0] wb_exc_cause_i,
  input  logic                      wb_dbg_trap_i,
  input  logic [`RVFI_DCAUSE_W-1:0] wb_dbg_trap_cause_i,
  input  logic                      irq_ack_i,
  input  logic [`RVFI_ECAUSE_W-1:0] irq_cause_i,
  input  logic                      debug_mode_i,
  output logic                      rvfi_valid_o,
  output rvfi_trap_u                rvfi_trap_o,
  output logic                      rvfi_intr_o,
  output logic [`RVFI_DCAUSE_W-1:0] rvfi_dbg_o,
  output logic [`RVFI_XLEN-1:0]     rvfi_mcause_o
);

  rvfi_trap_u               trap_d;
  logic                     retire;
  logic [`RVFI_XLEN-1:0]    mcause_q;

  // Causes only show up when their event is present
  always_comb begin
    trap_d.f.exception       = wb_exc_i;
    trap_d.f.debug           = wb_dbg_trap_i;
    trap_d.f.trap            = wb_exc_i | wb_dbg_trap_i;
    trap_d.f.exception_cause = wb_exc_i ? wb_exc_cause_i : '0;
    trap_d.f.debug_cause     = wb_dbg_trap_i ? wb_dbg_trap_cause_i : '0;
  end

  assign retire = step_i & wb_valid_i;

  //////////////////////////////////////////////////////////////////////
  // Control and CSR shadow
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvfi_valid_o  <= 1'b0;
      mcause_q      <= '0;
      rvfi_mcause_o <= '0;
    end else begin
      rvfi_valid_o <= retire;
      // Debug mode entry leaves mcause untouched
      if (irq_ack_i && !debug_mode_i) begin
        mcause_q <= {{(`RVFI_XLEN - `RVFI_ECAUSE_W){1'b0}}, irq_cause_i};
      end
      // The record shows mcause as it stood on the retiring step
      if (retire) begin
        rvfi_mcause_o <= mcause_q;
      end
    end
  end

  // Record payload, only meaningful while rvfi_valid_o is high
  always_ff @(posedge clk_i) begin
    if (retire) begin
      rvfi_trap_o <= trap_d;
      rvfi_intr_o <= wb_intr_i;
      rvfi_dbg_o  <= wb_dbg_i;
    end
  end

endmodule

// ==== hdl/rvfi_trap_checker.sv ====
/*
 * Trace consistency checker
 * Compares each retired record with the one before it and raises a
 * sticky flag for every rule that the event stream breaks
 */
`timescale 1ns/1ps
`include "rvfi_params.svh"

module rvfi_trap_checker import rvfi_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      rvfi_valid_i,
  input  rvfi_trap_u                rvfi_trap_i,
  input  logic                      rvfi_intr_i,
  input  logic [`RVFI_DCAUSE_W-1:0] rvfi_dbg_i,
  input  logic [`RVFI_XLEN-1:0]     rvfi_mcause_i,
  input  logic                      debug_mode_i,
  input  logic                      nmi_pending_i,
  output logic [`CHK_NUM_RULES-1:0] err_o
);

  // Trap word of the last retired record
  rvfi_trap_u prev_q;

  // Conditions that must hold from the last record up to this one
  logic no_dbg_q;
  logic no_nmi_q;
  logic held_no_dbg;
  logic held_no_nmi;
  logic mcause_ok;

  logic [`CHK_NUM_RULES-1:0] viol;

  // Include the current cycle in the window
  assign held_no_dbg = no_dbg_q & ~debug_mode_i;
  assign held_no_nmi = no_nmi_q & ~nmi_pending_i;

  // Handler entry must report the cause the trapping record carried
  assign mcause_ok = rvfi_mcause_i[`RVFI_ECAUSE_W-1:0] == prev_q.f.exception_cause;

  //////////////////////////////////////////////////////////////////////
  // Rules
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    viol = '0;

    // Any trap without debug in between must be followed by handler entry,
    // and an exception without NMI in between must also match mcause
    viol[`CHK_TRAP_NO_INTR] = ((|prev_q.raw) && held_no_dbg && !rvfi_intr_i) ||
                              (prev_q.f.exception && held_no_dbg && held_no_nmi &&
                               (!rvfi_intr_i || !mcause_ok));

    // Debug trap must be followed by a debug entry record
    viol[`CHK_TRAP_NO_DBG] = prev_q.f.debug && (rvfi_dbg_i == '0);

    // ... with the same cause
    viol[`CHK_DBG_CAUSE] = prev_q.f.debug && (rvfi_dbg_i != prev_q.f.debug_cause);

    // Exception together with debug can only come from single step
    viol[`CHK_STEP_CAUSE] = rvfi_trap_i.f.exception && rvfi_trap_i.f.debug &&
                            (rvfi_trap_i.f.debug_cause != `DBG_CAUSE_STEP);

    // Step entry needs a step trap first, unless an interrupt took over
    viol[`CHK_STEP_NO_TRAP] = (rvfi_dbg_i == `DBG_CAUSE_STEP) &&
                              (prev_q.f.debug_cause != `DBG_CAUSE_STEP) &&
                              !rvfi_intr_i;
  end

  //////////////////////////////////////////////////////////////////////
  // History and sticky flags
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prev_q   <= '0;
      no_dbg_q <= 1'b0;
      no_nmi_q <= 1'b0;
      err_o    <= '0;
    end else begin
      if (rvfi_valid_i) begin
        prev_q   <= rvfi_trap_i;
        // A new window opens at this record
        no_dbg_q <= ~debug_mode_i;
        no_nmi_q <= ~nmi_pending_i;
        err_o    <= err_o | viol;
      end else begin
        no_dbg_q <= held_no_dbg;
        no_nmi_q <= held_no_nmi;
      end
    end
  end

endmodule

// ==== hdl/rvfi_trace_top.sv ====
/*
 * Retirement trace unit top level
 * Connects trap capture, record retirement and the consistency checker
 */
`timescale 1ns/1ps
`include "rvfi_params.svh"

module rvfi_trace_top import rvfi_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      step_i,
  input  logic                      fetch_valid_i,
  input  logic                      irq_ack_i,
  input  logic [`RVFI_ECAUSE_W-1:0] irq_cause_i,
  input  logic                      dbg_ack_i,
  input  logic [`RVFI_DCAUSE_W-1:0] dbg_cause_i,
  input  logic                      debug_mode_i,
  input  logic                      nmi_pending_i,
  input  logic                      wb_exc_i,
  input  logic [`RVFI_ECAUSE_W-1:0] wb_exc_cause_i,
  input  logic                      wb_dbg_trap_i,
  input  logic [`RVFI_DCAUSE_W-1:0] wb_dbg_trap_cause_i,
  output logic                      rvfi_valid_o,
  output rvfi_trap_u                rvfi_trap_o,
  output logic                      rvfi_intr_o,
  output logic [`RVFI_DCAUSE_W-1:0] rvfi_dbg_o,
  output logic [`RVFI_XLEN-1:0]     rvfi_mcause_o,
  output logic [`CHK_NUM_RULES-1:0] err_o
);

  // WB slot from capture into retirement
  logic                      wb_valid;
  logic                      wb_intr;
  logic [`RVFI_DCAUSE_W-1:0] wb_dbg;

  trap_capture capture_i (
    .clk_i, .rst_ni, .step_i, .fetch_valid_i, .irq_ack_i, .dbg_ack_i, .dbg_cause_i,
    .wb_valid_o (wb_valid),
    .wb_intr_o  (wb_intr),
    .wb_dbg_o   (wb_dbg)
  );

  rvfi_retire retire_i (
    .clk_i, .rst_ni, .step_i,
    .wb_valid_i (wb_valid),
    .wb_intr_i  (wb_intr),
    .wb_dbg_i   (wb_dbg),
    .wb_exc_i, .wb_exc_cause_i, .wb_dbg_trap_i, .wb_dbg_trap_cause_i,
    .irq_ack_i, .irq_cause_i, .debug_mode_i,
    .rvfi_valid_o, .rvfi_trap_o, .rvfi_intr_o, .rvfi_dbg_o, .rvfi_mcause_o
  );

  // The checker watches the same trace that leaves the top level
  rvfi_trap_checker checker_i (
    .clk_i, .rst_ni,
    .rvfi_valid_i  (rvfi_valid_o),
    .rvfi_trap_i   (rvfi_trap_o),
    .rvfi_intr_i   (rvfi_intr_o),
    .rvfi_dbg_i    (rvfi_dbg_o),
    .rvfi_mcause_i (rvfi_mcause_o),
    .debug_mode_i, .nmi_pending_i, .err_o
  );

endmodule

// ==== tb/rvfi_trace_model.svh ====
/*
 * Reference model of the retirement trace unit
 * Pipeline slots, mcause shadow, checker rules and typed compare tasks
 */
`ifndef RVFI_TRACE_MODEL_SVH
`define RVFI_TRACE_MODEL_SVH

// Slot 0 is IF and the top slot is WB
logic [`RVFI_NSTAGES-1:0]                     m_valid;
logic [`RVFI_NSTAGES-1:0]                     m_intr;
logic [`RVFI_NSTAGES-1:0][`RVFI_DCAUSE_W-1:0] m_dbg;
logic [`RVFI_XLEN-1:0]                        m_mcause;

// Expected trace record and checker history
logic                      m_rec_valid;
rvfi_trap_u                m_rec_trap;
logic                      m_rec_intr;
logic [`RVFI_DCAUSE_W-1:0] m_rec_dbg;
logic [`RVFI_XLEN-1:0]     m_rec_mcause;
rvfi_trap_u                m_prev;
logic                      m_no_dbg;
logic                      m_no_nmi;
logic [`CHK_NUM_RULES-1:0] m_err;

task automatic reset_model();
  m_valid      = '0;
  m_intr       = '0;
  m_dbg        = '0;
  m_mcause     = '0;
  m_rec_valid  = 1'b0;
  m_rec_trap   = '0;
  m_rec_intr   = 1'b0;
  m_rec_dbg    = '0;
  m_rec_mcause = '0;
  m_prev       = '0;
  m_no_dbg     = 1'b0;
  m_no_nmi     = 1'b0;
  m_err        = '0;
endtask

// Rules applied to the current record against the previous trap word
function automatic logic [`CHK_NUM_RULES-1:0] predict_violations();
  logic [`CHK_NUM_RULES-1:0] v;
  logic quiet_dbg;
  logic quiet_nmi;
  v = '0;
  quiet_dbg = m_no_dbg && !debug_mode_i;
  quiet_nmi = m_no_nmi && !nmi_pending_i;
  // A trap with no debug in between must lead into the handler
  if (m_prev.raw != '0 && quiet_dbg && !m_rec_intr)
    v[`CHK_TRAP_NO_INTR] = 1'b1;
  // After an exception the handler also sees its cause in mcause, unless an NMI came
  if (m_prev.f.exception && quiet_dbg && quiet_nmi &&
      (!m_rec_intr || m_rec_mcause[`RVFI_ECAUSE_W-1:0] != m_prev.f.exception_cause))
    v[`CHK_TRAP_NO_INTR] = 1'b1;
  if (m_prev.f.debug && m_rec_dbg == '0)
    v[`CHK_TRAP_NO_DBG] = 1'b1;
  if (m_prev.f.debug && m_rec_dbg != m_prev.f.debug_cause)
    v[`CHK_DBG_CAUSE] = 1'b1;
  if (m_rec_trap.f.exception && m_rec_trap.f.debug &&
      m_rec_trap.f.debug_cause != `DBG_CAUSE_STEP)
    v[`CHK_STEP_CAUSE] = 1'b1;
  if (m_rec_dbg == `DBG_CAUSE_STEP && m_prev.f.debug_cause != `DBG_CAUSE_STEP && !m_rec_intr)
    v[`CHK_STEP_NO_TRAP] = 1'b1;
  return v;
endfunction

// One clock edge of the unit, from the inputs that are driven right now
task automatic advance_model();
  rvfi_trap_u word;
  logic       retiring;
  if (m_rec_valid) begin
    m_err    = m_err | predict_violations();
    m_prev   = m_rec_trap;
    m_no_dbg = !debug_mode_i;
    m_no_nmi = !nmi_pending_i;
  end else begin
    m_no_dbg = m_no_dbg && !debug_mode_i;
    m_no_nmi = m_no_nmi && !nmi_pending_i;
  end
  retiring    = step_i && m_valid[`RVFI_NSTAGES-1];
  m_rec_valid = retiring;
  if (retiring) begin
    word                   = '0;
    word.f.exception       = wb_exc_i;
    word.f.debug           = wb_dbg_trap_i;
    word.f.trap            = wb_exc_i || wb_dbg_trap_i;
    if (wb_exc_i)
      word.f.exception_cause = wb_exc_cause_i;
    if (wb_dbg_trap_i)
      word.f.debug_cause = wb_dbg_trap_cause_i;
    m_rec_trap   = word;
    m_rec_intr   = m_intr[`RVFI_NSTAGES-1];
    m_rec_dbg    = m_dbg[`RVFI_NSTAGES-1];
    m_rec_mcause = m_mcause;
  end
  if (irq_ack_i && !debug_mode_i)
    m_mcause = `RVFI_XLEN'(irq_cause_i);
  if (step_i) begin
    m_valid = {m_valid[`RVFI_NSTAGES-2:0], fetch_valid_i};
    m_intr  = {m_intr[`RVFI_NSTAGES-2:0], 1'b0};
    m_dbg   = {m_dbg[`RVFI_NSTAGES-2:0], {`RVFI_DCAUSE_W{1'b0}}};
  end
  if (irq_ack_i)
    m_intr[0] = 1'b1;
  if (dbg_ack_i)
    m_dbg[0] = dbg_cause_i;
endtask

task automatic check_valid(input logic exp);
  if (rvfi_valid_o !== exp) begin
    $display("Error at %0t: rvfi_valid_o is %b, expected %b", $time, rvfi_valid_o, exp);
    report_failure();
  end
endtask

task automatic check_mcause(input logic [`RVFI_XLEN-1:0] exp);
  if (rvfi_mcause_o !== exp) begin
    $display("Error at %0t: rvfi_mcause_o is %h, expected %h", $time, rvfi_mcause_o, exp);
    report_failure();
  end
endtask

task automatic check_record(input rvfi_trap_u exp_trap, input logic exp_intr,
                            input logic [`RVFI_DCAUSE_W-1:0] exp_dbg);
  if (rvfi_trap_o !== exp_trap || rvfi_intr_o !== exp_intr || rvfi_dbg_o !== exp_dbg) begin
    $display("Error at %0t: record trap %h intr %b dbg %h, expected trap %h intr %b dbg %h",
             $time, rvfi_trap_o.raw, rvfi_intr_o, rvfi_dbg_o, exp_trap.raw, exp_intr, exp_dbg);
    report_failure();
  end
endtask

task automatic check_err(input logic [`CHK_NUM_RULES-1:0] exp);
  if (err_o !== exp) begin
    $display("Error at %0t: err_o is %b, expected %b", $time, err_o, exp);
    report_failure();
  end
endtask

task automatic compare_outputs();
  check_valid(m_rec_valid);
  check_mcause(m_rec_mcause);
  check_err(m_err);
  if (m_rec_valid)
    check_record(m_rec_trap, m_rec_intr, m_rec_dbg);
endtask
`endif

// ==== tb/tb_rvfi_trace.sv ====
/*
 * Testbench for the retirement trace unit
 * Plays the core with seeded random events and checks the trace each cycle
 */
`timescale 1ns/1ps
`include "rvfi_params.svh"

module tb_rvfi_trace import rvfi_pkg::*; ();

  localparam int RESET_CYCLES      = 8;
  localparam int CONSISTENT_CYCLES = 600;
  localparam int NUM_CYCLES        = 2000;
  localparam int EPISODES          = 4;
  localparam int EPISODE_CYCLES    = 3 * `RVFI_NSTAGES + 2;
  localparam int TIMEOUT_NS        = (NUM_CYCLES + 3 * EPISODES * EPISODE_CYCLES +
                                      RESET_CYCLES + 20) * 40;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      step_i;
  logic                      fetch_valid_i;
  logic                      irq_ack_i;
  logic [`RVFI_ECAUSE_W-1:0] irq_cause_i;
  logic                      dbg_ack_i;
  logic [`RVFI_DCAUSE_W-1:0] dbg_cause_i;
  logic                      debug_mode_i;
  logic                      nmi_pending_i;
  logic                      wb_exc_i;
  logic [`RVFI_ECAUSE_W-1:0] wb_exc_cause_i;
  logic                      wb_dbg_trap_i;
  logic [`RVFI_DCAUSE_W-1:0] wb_dbg_trap_cause_i;
  logic                      rvfi_valid_o;
  rvfi_trap_u                rvfi_trap_o;
  logic                      rvfi_intr_o;
  logic [`RVFI_DCAUSE_W-1:0] rvfi_dbg_o;
  logic [`RVFI_XLEN-1:0]     rvfi_mcause_o;
  logic [`CHK_NUM_RULES-1:0] err_o;
  integer                    seed;

  rvfi_trace_top dut_i (
    .clk_i, .rst_ni, .step_i, .fetch_valid_i, .irq_ack_i, .irq_cause_i,
    .dbg_ack_i, .dbg_cause_i, .debug_mode_i, .nmi_pending_i,
    .wb_exc_i, .wb_exc_cause_i, .wb_dbg_trap_i, .wb_dbg_trap_cause_i,
    .rvfi_valid_o, .rvfi_trap_o, .rvfi_intr_o, .rvfi_dbg_o, .rvfi_mcause_o, .err_o
  );

  `include "rvfi_trace_model.svh"

  task automatic report_failure();
    $display("tests failed");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  ////////////////////////////////////////////////////////////////////
  // Core event stimulus
  ////////////////////////////////////////////////////////////////////

  // Steps and fetches are frequent while acknowledges and traps are rare
  task automatic drive_core_events(input logic allow_traps);
    logic [31:0] r;
    logic [31:0] r2;
    r  = $random(seed);
    r2 = $random(seed);
    step_i              = r[0] | r[1];
    fetch_valid_i       = r[2] | r[3];
    irq_ack_i           = (r[6:4] == 3'd0);
    irq_cause_i         = r[12:7];
    // Debug entries and WB traps only show up once traps are allowed
    dbg_ack_i           = allow_traps && (r[15:13] == 3'd0);
    dbg_cause_i         = r2[13] ? `DBG_CAUSE_STEP : r[18:16];
    debug_mode_i        = (r[21:19] == 3'd0);
    nmi_pending_i       = (r[24:22] == 3'd0);
    wb_exc_i            = allow_traps && (r[27:25] == 3'd0);
    wb_exc_cause_i      = r2[12:7];
    wb_dbg_trap_i       = allow_traps && (r2[2:0] == 3'd0);
    wb_dbg_trap_cause_i = r2[3] ? `DBG_CAUSE_STEP : r2[6:4];
  endtask

  // All strobes and levels low, causes keep their last value
  task automatic drive_quiet_events();
    step_i        = 1'b0;
    fetch_valid_i = 1'b0;
    irq_ack_i     = 1'b0;
    dbg_ack_i     = 1'b0;
    debug_mode_i  = 1'b0;
    nmi_pending_i = 1'b0;
    wb_exc_i      = 1'b0;
    wb_dbg_trap_i = 1'b0;
  endtask

  // One clock edge with the inputs as driven now, compared on the next falling edge
  task automatic clock_and_compare();
    advance_model();
    @(negedge clk_i);
    compare_outputs();
  endtask

  // A lone instruction traps in WB and the proper entry follows on the next fetch
  task automatic play_trap_episode(input logic                      exc,
                                   input logic [`RVFI_ECAUSE_W-1:0] exc_cause,
                                   input logic                      dbg,
                                   input logic [`RVFI_DCAUSE_W-1:0] dbg_cause);
    drive_quiet_events();
    step_i = 1'b1;
    // Empty the pipeline, then fetch the instruction that will trap
    repeat (`RVFI_NSTAGES) clock_and_compare();
    fetch_valid_i = 1'b1;
    clock_and_compare();
    fetch_valid_i = 1'b0;
    repeat (`RVFI_NSTAGES - 1) clock_and_compare();
    // Retiring step with the trap, the entry acknowledge lands on the new fetch
    fetch_valid_i       = 1'b1;
    wb_exc_i            = exc;
    wb_exc_cause_i      = exc_cause;
    wb_dbg_trap_i       = dbg;
    wb_dbg_trap_cause_i = dbg_cause;
    irq_ack_i           = !dbg;
    irq_cause_i         = exc_cause;
    dbg_ack_i           = dbg;
    dbg_cause_i         = dbg_cause;
    debug_mode_i        = dbg;
    clock_and_compare();
    // Debug mode stays on while the entry instruction drains to its record
    fetch_valid_i = 1'b0;
    wb_exc_i      = 1'b0;
    wb_dbg_trap_i = 1'b0;
    irq_ack_i     = 1'b0;
    dbg_ack_i     = 1'b0;
    repeat (`RVFI_NSTAGES + 1) clock_and_compare();
  endtask

  // Exception entry, debug entry and a step over an exception, all well behaved
  task automatic play_consistent_episodes();
    for (int e = 0; e < EPISODES; e++) begin
      play_trap_episode(1'b1, `RVFI_ECAUSE_W'($random(seed)), 1'b0, '0);
      play_trap_episode(1'b0, '0, 1'b1, 3'h1);
      play_trap_episode(1'b1, `RVFI_ECAUSE_W'($random(seed)), 1'b1, `DBG_CAUSE_STEP);
    end
    // Handler entries with matching causes must leave the checker quiet
    check_err('0);
  endtask

  always #20 clk_i = ~clk_i;

  initial begin
    seed                = 32'h92f02518;
    clk_i               = 1'b0;
    rst_ni              = 1'b0;
    drive_core_events(1'b0);
    step_i              = 1'b0;
    fetch_valid_i       = 1'b0;
    irq_ack_i           = 1'b0;
    debug_mode_i        = 1'b0;
    nmi_pending_i       = 1'b0;
    reset_model();
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    // Nothing has stepped yet, so the trace is idle and clean
    @(negedge clk_i);
    check_valid(1'b0);
    check_mcause('0);
    check_err('0);
    // The first stretch has no traps or debug entries, so no rule can fire
    for (int c = 0; c < NUM_CYCLES; c++) begin
      // Directed trap episodes sit between the clean stretch and the random traps
      if (c == CONSISTENT_CYCLES) begin
        play_consistent_episodes();
      end
      drive_core_events(c >= CONSISTENT_CYCLES);
      clock_and_compare();
    end
    $display("all tests passed");
    $finish;
  end

  // Watchdog sized from the cycle count plus some slack
  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired before the stimulus loop finished");
    report_failure();
  end

endmodule

// ==== compile.f ====
+incdir+hdl
+incdir+tb
hdl/rvfi_pkg.sv
hdl/trap_capture.sv
hdl/rvfi_retire.sv
hdl/rvfi_trap_checker.sv
hdl/rvfi_trace_top.sv
tb/tb_rvfi_trace.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the retirement trace testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_rvfi_trace -f compile.f -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/Vtb_rvfi_trace
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi
exit 0
